// ==== rom_image.hex ====
// boot image, one 32-bit word per line in hex.
// line n after these comments is word n, at rom byte address 4*n.
00000297
02028293
0002a303
0042a383
00638433
01c0006f
deadbeef
cafef00d
12345678
9abcdef0
0f1e2d3c
4b5a6978
87a5c3e1
ffffffff
80000001
7fffffff
a5a5a5a5
5a5a5a5a
00000000
13579bdf
2468ace0
fedcba98
76543210
01010101
10101010
c0ffee00
0badf00d
feedface
11223344
55667788
99aabbcc
ddeeff00

// ==== flist.f ====
design/wb_boot_pkg.sv
design/sram_rom.sv
design/wb_rom.sv
design/wb_ram.sv
design/wb_intercon.sv
design/boot_copier.sv
design/wb_boot_sys.sv
tests/tb_wb_boot_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the boot subsystem testbench with verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_wb_boot_sys -f flist.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi

// ==== tests/tb_wb_boot_sys.sv ====
// ====================================================================
// testbench for the boot subsystem top level.
// expected words come from rom_image.hex in the project root.
// the rom loads that same file.
// ram contents are undefined until written.
// upper ram words get a full write before any partial write.
// every wait gives up after TIMEOUT_CYCLES clocks.
// ====================================================================
`timescale 1ns/1ps

module tb_wb_boot_sys;

  localparam int ROM_WORDS      = 32;
  localparam int RAM_WORDS      = 64;
  localparam int COPY_WORDS     = 16;
  localparam int TIMEOUT_CYCLES = 400;

  // one expected host reply.
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic        ack;
    logic        err;
    logic        use_dat;  // compare read data too.
  } expect_t;

  logic                 wb_clk_i;
  logic                 wb_rst_i;
  logic                 start_i;
  wb_boot_pkg::wb_req_t host_req;
  wb_boot_pkg::wb_rsp_t host_rsp;
  logic                 busy;
  logic                 done;
  logic [31:0]          checksum;

  logic [31:0] image  [ROM_WORDS];  // reference copy of the rom.
  logic [31:0] shadow [RAM_WORDS];  // expected ram contents.
  expect_t     exp_q  [$];          // replies still due.
  int          errors;
  int          checks;
  int          timeouts;

  wb_boot_sys #(
    .ROM_WORDS  (ROM_WORDS),
    .RAM_WORDS  (RAM_WORDS),
    .COPY_WORDS (COPY_WORDS)
  ) dut_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .start_i    (start_i),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .busy_o     (busy),
    .done_o     (done),
    .checksum_o (checksum)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;  // 100 ns period.
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // wrapping sum of the first n image words.
  function automatic logic [31:0] ref_checksum(input int n);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < n; i++) sum = sum + image[i];
    return sum;
  endfunction

  // new bytes only where the lane is selected.
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  // compares each host reply with the oldest expectation.
  always @(negedge wb_clk_i) begin
    expect_t e;
    if (!wb_rst_i && (host_rsp.ack || host_rsp.err)) begin
      check_eq(32'(busy), 32'd0, "host reply while copier busy");
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: %0t ns: host reply with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_eq(32'(host_rsp.ack), 32'(e.ack), $sformatf("ack at %08h", e.adr));
        check_eq(32'(host_rsp.err), 32'(e.err), $sformatf("err at %08h", e.adr));
        if (e.use_dat) check_eq(host_rsp.dat, e.dat, $sformatf("read data at %08h", e.adr));
      end
    end
  end

  // one classic cycle held until ack or err.
  task automatic host_access(input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, input logic we, input expect_t exp,
                             output int waits);
    int cycles;
    bit replied;
    cycles  = 0;
    replied = 1'b0;
    exp_q.push_back(exp);
    @(negedge wb_clk_i);
    host_req = '{adr: adr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    while (!replied && cycles < TIMEOUT_CYCLES) begin
      @(negedge wb_clk_i);
      cycles++;
      replied = host_rsp.ack | host_rsp.err;
    end
    host_req.cyc = 1'b0;  // adr held so the decode stays put.
    host_req.stb = 1'b0;
    waits = cycles - 1;
    if (!replied) begin
      timeouts++;
      exp_q.delete(exp_q.size() - 1);
      $display("ERROR: %0t ns: no host reply for address %08h", $time, adr);
    end
  endtask

  task automatic read_check(input logic [31:0] adr, input logic [31:0] exp_dat, output int waits);
    host_access(adr, '0, 4'hF, 1'b0,
                '{adr: adr, dat: exp_dat, ack: 1'b1, err: 1'b0, use_dat: 1'b1}, waits);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat, input logic [3:0] sel);
    int waits;
    host_access(adr, wdat, sel, 1'b1, '{adr: adr, dat: '0, ack: 1'b1, err: 1'b0, use_dat: 1'b0},
                waits);
  endtask

  task automatic expect_err(input logic [31:0] adr, input logic we);
    int waits;
    host_access(adr, 32'h5555_aaaa, 4'hF, we,
                '{adr: adr, dat: '0, ack: 1'b0, err: 1'b1, use_dat: 1'b0}, waits);
  endtask

  task automatic pulse_start();
    @(negedge wb_clk_i);
    start_i = 1'b1;
    @(negedge wb_clk_i);
    start_i = 1'b0;
  endtask

  // waits for done_o or busy_o to be high.
  task automatic wait_for(input bit want_done, input string what);
    int cycles;
    cycles = 0;
    while (((want_done ? done : busy) !== 1'b1) && cycles < TIMEOUT_CYCLES) begin
      @(negedge wb_clk_i);
      cycles++;
    end
    if ((want_done ? done : busy) !== 1'b1) begin
      timeouts++;
      $display("ERROR: %0t ns: timed out waiting for %s", $time, what);
    end
  endtask

  task automatic check_idle(input string when);
    check_eq(32'(host_rsp.ack), 32'd0, {"host ack ", when});
    check_eq(32'(host_rsp.err), 32'd0, {"host err ", when});
    check_eq(32'(busy), 32'd0, {"busy_o ", when});
    check_eq(32'(done), 32'd0, {"done_o ", when});
    check_eq(checksum, 32'd0, {"checksum_o ", when});
  endtask

  initial begin
    int          waits;
    int          idx;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [3:0]  sel;
    void'($urandom(5));
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    wb_rst_i = 1'b1;
    start_i  = 1'b0;
    host_req = '0;
    $readmemh("rom_image.hex", image);
    repeat (2) begin  // reset held two cycles.
      @(negedge wb_clk_i);
      check_idle("in reset");
    end
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    check_idle("after reset");

    pulse_start();  // first copy.
    wait_for(1'b1, "done_o after start");
    check_eq(checksum, ref_checksum(COPY_WORDS), "checksum after copy");
    for (int i = 0; i < COPY_WORDS; i++) shadow[i] = image[i];

    for (int i = 0; i < COPY_WORDS; i++) begin
      read_check(wb_boot_pkg::RAM_BASE + 32'(4 * i), shadow[i], waits);
    end
    repeat (8) begin  // random rom reads.
      idx = int'($urandom_range(ROM_WORDS - 1));
      read_check(wb_boot_pkg::ROM_BASE + 32'(4 * idx), image[idx], waits);
    end

    for (int i = COPY_WORDS; i < RAM_WORDS; i++) begin
      wdat = $urandom;
      write_word(wb_boot_pkg::RAM_BASE + 32'(4 * i), wdat, 4'hF);
      shadow[i] = wdat;
    end
    repeat (24) begin  // partial writes.
      idx  = COPY_WORDS + int'($urandom_range(RAM_WORDS - COPY_WORDS - 1));
      wdat = $urandom;
      sel  = 4'($urandom);
      write_word(wb_boot_pkg::RAM_BASE + 32'(4 * idx), wdat, sel);
      shadow[idx] = merge_lanes(shadow[idx], wdat, sel);
    end
    for (int i = COPY_WORDS; i < RAM_WORDS; i++) begin
      read_check(wb_boot_pkg::RAM_BASE + 32'(4 * i), shadow[i], waits);
    end

    idx = int'($urandom_range(ROM_WORDS - 1));  // rom is read only.
    expect_err(wb_boot_pkg::ROM_BASE + 32'(4 * idx), 1'b1);
    read_check(wb_boot_pkg::ROM_BASE + 32'(4 * idx), image[idx], waits);
    repeat (6) begin
      adr = ($urandom & 32'h0001_fffc) | (32'h1 << (17 + $urandom_range(14)));
      expect_err(adr, 1'($urandom_range(1)));
    end

    pulse_start();  // second copy with a host read stalled behind it.
    wait_for(1'b0, "busy_o after start");
    read_check(wb_boot_pkg::RAM_BASE + 32'd12, shadow[3], waits);
    check_eq(32'(waits > 0), 32'd1, "host read stalled behind copy");
    wait_for(1'b1, "done_o after second copy");
    check_eq(checksum, ref_checksum(COPY_WORDS), "checksum after second copy");

    @(negedge wb_clk_i);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== design/wb_boot_sys.sv ====
// ====================================================================
// boot subsystem top: copier, interconnect, rom and ram.
// host port is a plain wishbone classic master port.
// host accesses stall while busy_o is high.
// keep COPY_WORDS <= ROM_WORDS and COPY_WORDS <= RAM_WORDS.
// ====================================================================
`timescale 1ns/1ps

module wb_boot_sys #(
  parameter int ROM_WORDS  = 32,
  parameter int RAM_WORDS  = 64,
  parameter int COPY_WORDS = 16
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 start_i,     // kicks off the copy.
  input  wb_boot_pkg::wb_req_t host_req_i,
  output wb_boot_pkg::wb_rsp_t host_rsp_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [31:0]          checksum_o
);

  wb_boot_pkg::wb_req_t cpu_req;  // copier side.
  wb_boot_pkg::wb_rsp_t cpu_rsp;
  wb_boot_pkg::wb_req_t rom_req;
  wb_boot_pkg::wb_rsp_t rom_rsp;
  wb_boot_pkg::wb_req_t ram_req;
  wb_boot_pkg::wb_rsp_t ram_rsp;

  boot_copier #(
    .COPY_WORDS (COPY_WORDS)
  ) u_copier (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .start_i    (start_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .checksum_o (checksum_o),
    .req_o      (cpu_req),
    .rsp_i      (cpu_rsp)
  );

  wb_intercon u_intercon (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cpu_req_i     (cpu_req),
    .cpu_rsp_o     (cpu_rsp),
    .host_req_i    (host_req_i),
    .host_rsp_o    (host_rsp_o),
    .copier_busy_i (busy_o),  // grant follows the copy.
    .rom_req_o     (rom_req),
    .rom_rsp_i     (rom_rsp),
    .ram_req_o     (ram_req),
    .ram_rsp_i     (ram_rsp)
  );

  wb_rom #(
    .ROM_WORDS (ROM_WORDS)
  ) u_rom (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .req_i    (rom_req),
    .rsp_o    (rom_rsp)
  );

  wb_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .req_i    (ram_req),
    .rsp_o    (ram_rsp)
  );

endmodule

// ==== design/boot_copier.sv ====
// ====================================================================
// boot copier, wishbone classic master.
// copies COPY_WORDS words rom -> ram, one read then one write each.
// checksum is the 32-bit wrapping sum of the words read.
// a start_i pulse is only taken when idle or done.
// COPY_WORDS must not exceed the rom or ram size.
// ====================================================================
`timescale 1ns/1ps

module boot_copier #(
  parameter int COPY_WORDS = 16
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 start_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [31:0]          checksum_o,
  output wb_boot_pkg::wb_req_t req_o,
  input  wb_boot_pkg::wb_rsp_t rsp_i
);

  localparam int CW = $clog2(COPY_WORDS + 1);  // word counter width.

  wb_boot_pkg::copier_state_e state_q;

  logic [CW-1:0] idx_q;       // current word.
  logic [31:0]   data_q;      // word held between read and write.
  logic [31:0]   checksum_q;
  logic          done_q;
  logic          last_word;
  logic          is_write;
  logic [31:0]   byte_off;    // 4 * idx.

  assign last_word = (idx_q == CW'(COPY_WORDS - 1));
  assign is_write  = (state_q == wb_boot_pkg::CP_WRITE);
  assign byte_off  = 32'(idx_q) << 2;

  // fsm, counter, latch and checksum.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q    <= wb_boot_pkg::CP_IDLE;
      idx_q      <= '0;
      data_q     <= '0;
      checksum_q <= '0;
      done_q     <= 1'b0;
    end else begin
      case (state_q)
        wb_boot_pkg::CP_IDLE, wb_boot_pkg::CP_DONE: begin
          if (start_i) begin  // fresh run.
            state_q    <= wb_boot_pkg::CP_READ;
            idx_q      <= '0;
            checksum_q <= '0;
            done_q     <= 1'b0;
          end
        end
        wb_boot_pkg::CP_READ: begin
          if (rsp_i.ack) begin
            data_q     <= rsp_i.dat;
            checksum_q <= checksum_q + rsp_i.dat;  // wraps mod 2^32.
            state_q    <= wb_boot_pkg::CP_WRITE;
          end
        end
        wb_boot_pkg::CP_WRITE: begin
          if (rsp_i.ack) begin
            if (last_word) begin
              state_q <= wb_boot_pkg::CP_DONE;
              done_q  <= 1'b1;  // held until next start.
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= wb_boot_pkg::CP_READ;
            end
          end
        end
        default: state_q <= wb_boot_pkg::CP_IDLE;
      endcase
    end
  end

  assign busy_o     = (state_q == wb_boot_pkg::CP_READ) | is_write;
  assign done_o     = done_q;
  assign checksum_o = checksum_q;

  // request follows the state, held stable until ack.
  always_comb begin
    req_o.cyc = busy_o;
    req_o.stb = busy_o;
    req_o.we  = is_write;
    req_o.sel = 4'hF;  // whole words only.
    req_o.dat = data_q;
    req_o.adr = (is_write ? wb_boot_pkg::RAM_BASE : wb_boot_pkg::ROM_BASE) + byte_off;
  end

endmodule

// ==== design/wb_intercon.sv ====
// ====================================================================
// two-master, two-slave wishbone classic interconnect.
// the copier owns the bus while busy; the host owns it otherwise.
// host requests during the copy get no reply and must wait.
// unmapped addresses get a registered one-cycle err.
// ====================================================================
`timescale 1ns/1ps

module wb_intercon (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // copier master.
  input  wb_boot_pkg::wb_req_t cpu_req_i,
  output wb_boot_pkg::wb_rsp_t cpu_rsp_o,
  // external host master.
  input  wb_boot_pkg::wb_req_t host_req_i,
  output wb_boot_pkg::wb_rsp_t host_rsp_o,
  input  logic                 copier_busy_i,  // grant to the copier.
  // rom slave.
  output wb_boot_pkg::wb_req_t rom_req_o,
  input  wb_boot_pkg::wb_rsp_t rom_rsp_i,
  // ram slave.
  output wb_boot_pkg::wb_req_t ram_req_o,
  input  wb_boot_pkg::wb_rsp_t ram_rsp_i
);

  wb_boot_pkg::wb_req_t own_req;  // request of the current owner.
  wb_boot_pkg::wb_rsp_t own_rsp;  // reply routed back to it.

  logic own_strobe;
  logic unmapped;   // some bit above the region bit set.
  logic hit_ram;
  logic hit_rom;
  logic err_q;

  // ownership.
  assign own_req    = copier_busy_i ? cpu_req_i : host_req_i;
  assign own_strobe = own_req.cyc & own_req.stb;

  // region decode.
  assign unmapped = |own_req.adr[31:wb_boot_pkg::REGION_SEL_BIT+1];
  assign hit_ram  = ~unmapped & own_req.adr[wb_boot_pkg::REGION_SEL_BIT];
  assign hit_rom  = ~unmapped & ~own_req.adr[wb_boot_pkg::REGION_SEL_BIT];

  // slaves see the request, but only the addressed one sees cyc/stb.
  always_comb begin
    rom_req_o     = own_req;
    rom_req_o.cyc = own_req.cyc & hit_rom;
    rom_req_o.stb = own_req.stb & hit_rom;
    ram_req_o     = own_req;
    ram_req_o.cyc = own_req.cyc & hit_ram;
    ram_req_o.stb = own_req.stb & hit_ram;
  end

  // unmapped err, one cycle, then low for at least one.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= own_strobe & unmapped & ~err_q;
    end
  end

  // response mux, addr is stable until the reply so decode holds.
  always_comb begin
    if (unmapped) begin
      own_rsp = '{dat: 32'h0, ack: 1'b0, err: err_q};
    end else if (hit_ram) begin
      own_rsp = ram_rsp_i;
    end else begin
      own_rsp = rom_rsp_i;
    end
  end

  // the master without the grant sees all zero.
  assign cpu_rsp_o  = copier_busy_i ? own_rsp : '0;
  assign host_rsp_o = copier_busy_i ? '0 : own_rsp;

endmodule

// ==== design/wb_ram.sv ====
// ====================================================================
// wishbone classic slave ram, 32-bit words, byte-lane writes.
// every request acks one cycle after strobe; err is never raised.
// contents are undefined after power up, reset does not clear them.
// address bits above the ram size alias back onto the array.
// ====================================================================
`timescale 1ns/1ps

module wb_ram #(
  parameter int RAM_WORDS = 64
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  wb_boot_pkg::wb_req_t req_i,
  output wb_boot_pkg::wb_rsp_t rsp_o
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [31:0]   rd_dat_q;  // read data, valid with ack.
  logic          ack_q;
  logic          accept;
  logic [AW-1:0] word_idx;

  assign accept   = req_i.cyc & req_i.stb & ~ack_q;  // gap of one after ack.
  assign word_idx = req_i.adr[AW+1:2];

  // control.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // array and read data.
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];  // lane b only.
          end
        end
      end else begin
        rd_dat_q <= mem[word_idx];
      end
    end
  end

  assign rsp_o = '{dat: rd_dat_q, ack: ack_q, err: 1'b0};

endmodule

// ==== design/wb_rom.sv ====
// ====================================================================
// wishbone classic slave wrapping the boot rom.
// reads ack one cycle after strobe; writes get err, never ack.
// address bits above the rom size alias back onto the array.
// ====================================================================
`timescale 1ns/1ps

module wb_rom #(
  parameter int ROM_WORDS = 32
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  wb_boot_pkg::wb_req_t req_i,
  output wb_boot_pkg::wb_rsp_t rsp_o
);

  localparam int AW = $clog2(ROM_WORDS);  // word index width.

  logic          ack_q;
  logic          err_q;
  logic          accept;    // new request this cycle.
  logic [AW-1:0] word_idx;
  logic [31:0]   rom_dat;

  // a request is taken only while no reply is out, so one reply each.
  assign accept   = req_i.cyc & req_i.stb & ~ack_q & ~err_q;
  assign word_idx = req_i.adr[AW+1:2];  // byte to word address.

  sram_rom #(
    .DEPTH (ROM_WORDS)
  ) u_rom (
    .wb_clk_i (wb_clk_i),
    .en_i     (accept & ~req_i.we),  // data lands with the ack.
    .addr_i   (word_idx),
    .dat_o    (rom_dat)
  );

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept & ~req_i.we;  // read.
      err_q <= accept & req_i.we;   // write to rom is refused.
    end
  end

  assign rsp_o = '{dat: rom_dat, ack: ack_q, err: err_q};

endmodule

// ==== design/sram_rom.sv ====
// ====================================================================
// synchronous-read rom, 32-bit words.
// contents come from rom_image.hex in the run directory.
// DEPTH should be a power of two; the file may hold fewer words.
// ====================================================================
`timescale 1ns/1ps

module sram_rom #(
  parameter int DEPTH = 32
) (
  input  logic                     wb_clk_i,
  input  logic                     en_i,    // read enable.
  input  logic [$clog2(DEPTH)-1:0] addr_i,  // word index.
  output logic [31:0]              dat_o
);

  logic [31:0] mem [DEPTH];  // image array.

  // image loaded once at elaboration.
  initial begin
    $readmemh("rom_image.hex", mem);
  end

  // output only moves when enabled, holds otherwise.
  always_ff @(posedge wb_clk_i) begin
    if (en_i) begin
      dat_o <= mem[addr_i];
    end
  end

endmodule

// ==== design/wb_boot_pkg.sv ====
// ====================================================================
// shared types and address map for the boot subsystem.
// wishbone classic only; no tags, no burst fields.
// rom sits at byte 0, ram at 0x0001_0000 (bit 16 picks the region).
// any address with a bit above bit 16 set is unmapped.
// ====================================================================

package wb_boot_pkg;

  // master request bundle.
  typedef struct packed {
    logic [31:0] adr;  // byte address.
    logic [31:0] dat;  // write data.
    logic [3:0]  sel;  // byte lanes.
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  // slave response bundle.
  typedef struct packed {
    logic [31:0] dat;  // read data, valid with ack.
    logic        ack;
    logic        err;
  } wb_rsp_t;

  // boot copier fsm states.
  typedef enum logic [1:0] {
    CP_IDLE  = 2'd0,
    CP_READ  = 2'd1,
    CP_WRITE = 2'd2,
    CP_DONE  = 2'd3
  } copier_state_e;

  // address map.
  localparam logic [31:0] ROM_BASE       = 32'h0000_0000;
  localparam logic [31:0] RAM_BASE       = 32'h0001_0000;
  localparam int          REGION_SEL_BIT = 16;

endpackage
